// ==== files.f ====
src/rv_isa_pkg.sv
src/core_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/exec_unit.sv
src/rv_core.sv
sim/rv_core_sva.sv
sim/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core -f files.f -o vtb_rv_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vtb_rv_core > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== sim/rv_core_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_sva (
    input wire sck,
    input wire i_rst_n,
    input wire i_cmd_valid,
    input wire i_wb_valid,
    input wire i_illegal
);

    // failures so far, read by the testbench
    int n_failed = 0;

    // write-back only two cycles after a command
    wb_after_cmd: assert property (@(posedge sck) disable iff (!i_rst_n)
        i_wb_valid |-> $past(i_cmd_valid, 2))
    else begin
        n_failed++;
        $error("write-back without a command two cycles earlier");
    end

    // an illegal command never reaches write-back
    illegal_no_wb: assert property (@(posedge sck) disable iff (!i_rst_n)
        i_illegal |=> !i_wb_valid)
    else begin
        n_failed++;
        $error("write-back follows an illegal command");
    end

    quiet_in_reset: assert property (@(posedge sck)
        !i_rst_n |-> (!i_wb_valid && !i_illegal))
    else begin
        n_failed++;
        $error("strobe high during reset");
    end

endmodule

bind rv_core rv_core_sva u_sva (
    .sck         (sck),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (i_cmd_valid),
    .i_wb_valid  (o_wb_valid),
    .i_illegal   (o_illegal)
);

`default_nettype wire

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int NUM_REGS      = 32;
    localparam int CLK_PERIOD_NS = 4;
    // reset, constants, 4 arith rounds, shifts, chain, x0/illegal, debug reads
    localparam int TEST_CYCLES   = 8 + 18 + 4 * 39 + 90 + 16 + 9 + 37;
    localparam int WATCHDOG_NS   = (TEST_CYCLES + 100) * CLK_PERIOD_NS;

    // add, sub, and, or, xor
    localparam rv_isa_pkg::funct3_t ALU_F3 [5] = '{
        rv_isa_pkg::F3_ADD_SUB, rv_isa_pkg::F3_ADD_SUB, rv_isa_pkg::F3_AND,
        rv_isa_pkg::F3_OR, rv_isa_pkg::F3_XOR
    };

    logic                sck;
    logic                i_rst_n;
    logic                i_cmd_valid;
    rv_isa_pkg::instr_t  i_cmd;
    core_pkg::reg_addr_t i_dbg_addr;
    core_pkg::data_t     o_dbg_data;
    logic                o_wb_valid;
    core_pkg::reg_addr_t o_wb_addr;
    core_pkg::data_t     o_wb_data;
    logic                o_illegal;

    // architectural state as the tests expect it
    logic [31:0] model [32];

    rv_core #(
        .NUM_REGS (NUM_REGS)
    ) u_dut (
        .sck         (sck),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd       (i_cmd),
        .i_dbg_addr  (i_dbg_addr),
        .o_dbg_data  (o_dbg_data),
        .o_wb_valid  (o_wb_valid),
        .o_wb_addr   (o_wb_addr),
        .o_wb_data   (o_wb_data),
        .o_illegal   (o_illegal)
    );

    initial begin
        sck = 1'b0;
        forever #(CLK_PERIOD_NS / 2) sck = ~sck;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    // stop at the first failure of a bound assertion
    initial begin
        wait (u_dut.u_sva.n_failed != 0);
        $display("a bound assertion on the core strobes failed");
        $display("Result: FAILED");
        $fatal(1, "bound assertion failed");
    end

    task automatic expect_equal(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAILED %s: expected %h, actual %h", what, exp, act);
            $display("Result: FAILED");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    function automatic rv_isa_pkg::instr_t r_type_word(input logic [6:0] f7,
        input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
        input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic rv_isa_pkg::instr_t i_type_word(input logic [2:0] f3,
        input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic rv_isa_pkg::instr_t lui_word(input logic [4:0] rd,
                                                    input logic [19:0] imm);
        return {imm, rd, rv_isa_pkg::OPC_LUI};
    endfunction

    function automatic logic [31:0] expected_alu(input logic [2:0] f3, input logic alt,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh = b[4:0];
        // sign bits shifted in from the top
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: return alt ? a - b : a + b;
            rv_isa_pkg::F3_SLL:     return a << sh;
            rv_isa_pkg::F3_SR:      return alt ? ((a >> sh) | fill) : (a >> sh);
            rv_isa_pkg::F3_XOR:     return a ^ b;
            rv_isa_pkg::F3_OR:      return a | b;
            rv_isa_pkg::F3_AND:     return a & b;
            default:                return 32'hx;
        endcase
    endfunction

    function automatic void model_result(input rv_isa_pkg::instr_t c, output logic wr,
                                         output logic ill, output logic [31:0] res);
        logic [6:0]  opc;
        logic [31:0] b;
        logic        alt;
        opc = c[6:0];
        b   = (opc == rv_isa_pkg::OPC_OP) ? model[c[24:20]] : {{20{c[31]}}, c[31:20]};
        // funct7 only means sub/sra for register ops and shift-right immediates
        alt = (c[31:25] == rv_isa_pkg::F7_ALT) &&
              ((opc == rv_isa_pkg::OPC_OP) || (c[14:12] == rv_isa_pkg::F3_SR));
        ill = 1'b0;
        res = '0;
        if (opc == rv_isa_pkg::OPC_LUI) begin
            res = {c[31:12], 12'h000};
        end else if ((opc == rv_isa_pkg::OPC_OP) || (opc == rv_isa_pkg::OPC_OP_IMM)) begin
            res = expected_alu(c[14:12], alt, model[c[19:15]], b);
        end else begin
            ill = 1'b1;
        end
        wr = !ill && (c[11:7] != 5'd0);
    endfunction

    // one command with illegal checked after 1 cycle and write-back after 2
    task automatic issue_and_check(input string name, input rv_isa_pkg::instr_t cmd);
        logic        wr;
        logic        ill;
        logic [31:0] res;
        model_result(cmd, wr, ill, res);
        @(posedge sck);
        #1;
        i_cmd_valid = 1'b1;
        i_cmd       = cmd;
        @(posedge sck);
        #1;
        i_cmd_valid = 1'b0;
        expect_equal({name, " illegal"}, 32'(ill), 32'(o_illegal));
        @(posedge sck);
        #1;
        expect_equal({name, " wb_valid"}, 32'(wr), 32'(o_wb_valid));
        expect_equal({name, " illegal width"}, 32'd0, 32'(o_illegal));
        if (wr) begin
            expect_equal({name, " wb_addr"}, 32'(cmd[11:7]), 32'(o_wb_addr));
            expect_equal({name, " wb_data"}, res, o_wb_data);
            model[cmd[11:7]] = res;
        end
    endtask

    task automatic load_constant(input string name, input logic [4:0] rd,
                                 input logic [31:0] value);
        logic [31:0] rounded;
        // round the upper part since addi sign-extends
        rounded = value + 32'h800;
        issue_and_check(name, lui_word(rd, rounded[31:12]));
        issue_and_check(name, i_type_word(rv_isa_pkg::F3_ADD_SUB, rd, rd, value[11:0]));
    endtask

    task automatic read_debug(input string name, input logic [4:0] addr);
        @(posedge sck);
        #1;
        i_dbg_addr = addr;
        #1;
        expect_equal({name, " debug read"}, model[addr], o_dbg_data);
    endtask

    task automatic compare_registers(input string name);
        for (int r = 0; r < 32; r++) begin
            read_debug(name, 5'(r));
        end
    endtask

    task automatic constants_test();
        load_constant("constants", 5'd1, 32'h1234_5678);
        load_constant("constants", 5'd2, 32'hdead_beef);
        issue_and_check("constants", i_type_word(rv_isa_pkg::F3_ADD_SUB, 5'd3, 5'd0, 12'hfff));
        issue_and_check("constants", lui_word(5'd4, 20'h80000));
        for (int r = 1; r <= 4; r++) begin
            read_debug("constants", 5'(r));
        end
    endtask

    task automatic arith_logic_test();
        rv_isa_pkg::funct7_t f7;
        logic [11:0]         imm;
        for (int n = 0; n < 4; n++) begin
            load_constant("arith_logic", 5'd5, $urandom());
            load_constant("arith_logic", 5'd6, $urandom());
            imm = 12'($urandom());
            for (int k = 0; k < 5; k++) begin
                f7 = (k == 1) ? rv_isa_pkg::F7_ALT : rv_isa_pkg::F7_BASE;
                issue_and_check("arith_logic", r_type_word(f7, ALU_F3[k], 5'(7 + k), 5'd5, 5'd6));
                // no subi in the isa
                if (k != 1) begin
                    issue_and_check("arith_logic", i_type_word(ALU_F3[k], 5'(12 + k), 5'd5, imm));
                end
            end
        end
    endtask

    task automatic shift_test();
        logic [4:0] amounts [4];
        amounts[0] = 5'd0;
        amounts[1] = 5'd1;
        amounts[2] = 5'd31;
        amounts[3] = 5'($urandom());
        load_constant("shift", 5'd16, $urandom() | 32'h8000_0000);
        for (int k = 0; k < 4; k++) begin
            // upper bits of the amount register are ignored
            issue_and_check("shift", i_type_word(rv_isa_pkg::F3_ADD_SUB, 5'd17, 5'd0,
                                                 {7'($urandom()), amounts[k]}));
            issue_and_check("shift", r_type_word(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLL,
                                                 5'd18, 5'd16, 5'd17));
            issue_and_check("shift", r_type_word(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SR,
                                                 5'd19, 5'd16, 5'd17));
            issue_and_check("shift", r_type_word(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_SR,
                                                 5'd20, 5'd16, 5'd17));
            issue_and_check("shift", i_type_word(rv_isa_pkg::F3_SLL, 5'd21, 5'd16,
                                                 {rv_isa_pkg::F7_BASE, amounts[k]}));
            issue_and_check("shift", i_type_word(rv_isa_pkg::F3_SR, 5'd22, 5'd16,
                                                 {rv_isa_pkg::F7_BASE, amounts[k]}));
            issue_and_check("shift", i_type_word(rv_isa_pkg::F3_SR, 5'd23, 5'd16,
                                                 {rv_isa_pkg::F7_ALT, amounts[k]}));
        end
    endtask

    // each command reads the destination of the one before it
    task automatic bypass_chain_test();
        logic               wr;
        logic               ill;
        logic [31:0]        res;
        logic [31:0]        exp_data [$];
        logic [4:0]         exp_addr [$];
        logic [4:0]         rd;
        rv_isa_pkg::instr_t cmd;
        load_constant("bypass_chain", 5'd10, $urandom());
        for (int i = 0; i < 10; i++) begin
            @(posedge sck);
            #1;
            i_cmd_valid = 1'b0;
            if (i < 8) begin
                rd = 5'(11 + i);
                case (i % 4)
                    0: cmd = r_type_word(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB,
                                         rd, rd - 5'd1, rd - 5'd1);
                    1: cmd = i_type_word(rv_isa_pkg::F3_XOR, rd, rd - 5'd1, 12'($urandom()));
                    2: cmd = r_type_word(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD_SUB,
                                         rd, 5'd10, rd - 5'd1);
                    default: cmd = i_type_word(rv_isa_pkg::F3_SLL, rd, rd - 5'd1, 12'd3);
                endcase
                model_result(cmd, wr, ill, res);
                model[rd] = res;
                exp_data.push_back(res);
                exp_addr.push_back(rd);
                i_cmd_valid = 1'b1;
                i_cmd       = cmd;
            end
            // write-back of the command from two cycles ago
            if (i >= 2) begin
                expect_equal("bypass_chain wb_valid", 32'd1, 32'(o_wb_valid));
                expect_equal("bypass_chain wb_addr", 32'(exp_addr.pop_front()), 32'(o_wb_addr));
                expect_equal("bypass_chain wb_data", exp_data.pop_front(), o_wb_data);
            end
        end
    endtask

    task automatic x0_and_illegal_test();
        issue_and_check("x0_write", r_type_word(rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD_SUB,
                                                5'd0, 5'd1, 5'd2));
        issue_and_check("x0_write", lui_word(5'd0, 20'hfffff));
        read_debug("x0_write", 5'd0);
        // unsupported branch opcode
        issue_and_check("illegal", {25'($urandom()), 7'b1100011});
        compare_registers("illegal");
    endtask

    initial begin
        void'($urandom(19));
        i_rst_n     = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd       = '0;
        i_dbg_addr  = '0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        #1;
        i_rst_n = 1'b0;
        repeat (8) @(posedge sck);
        #1;
        i_rst_n = 1'b1;

        constants_test();
        arith_logic_test();
        shift_test();
        bypass_chain_test();
        x0_and_illegal_test();

        if (u_dut.u_sva.n_failed == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("%0d bound assertion failures", u_dut.u_sva.n_failed);
            $display("Result: FAILED");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

`default_nettype wire

// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // datapath width
    localparam int XLEN = 32;

    // one register value
    typedef logic [XLEN-1:0] data_t;

    // register index, wide enough for the full RV32I set
    typedef logic [4:0] reg_addr_t;

    // operations of the execute unit
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        // forwards operand b, used by lui
        ALU_PASS
    } alu_op_e;

endpackage

`default_nettype wire

// ==== src/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire                     sck,
    input  wire                     i_rst_n,
    input  wire                     i_issue_valid,
    input  wire core_pkg::alu_op_e  i_alu_op,
    input  wire core_pkg::data_t    i_op_a,
    input  wire core_pkg::data_t    i_op_b,
    input  wire core_pkg::reg_addr_t i_rd_addr,
    output logic                    o_wr_en,
    output core_pkg::reg_addr_t     o_wr_addr,
    output core_pkg::data_t         o_wr_data,
    output logic                    o_wb_valid,
    output core_pkg::reg_addr_t     o_wb_addr,
    output core_pkg::data_t         o_wb_data
);

    logic            is_sub;
    logic [4:0]      shamt;
    core_pkg::data_t b_eff;
    core_pkg::data_t sum;
    core_pkg::data_t result;

    // one adder, sub is a + ~b + 1
    assign is_sub = (i_alu_op == core_pkg::ALU_SUB);
    assign b_eff  = i_op_b ^ {core_pkg::XLEN{is_sub}};
    assign sum    = i_op_a + b_eff + core_pkg::data_t'(is_sub);

    assign shamt = i_op_b[4:0];

    always_comb begin
        case (i_alu_op)
            core_pkg::ALU_ADD,
            core_pkg::ALU_SUB:  result = sum;
            core_pkg::ALU_AND:  result = i_op_a & i_op_b;
            core_pkg::ALU_OR:   result = i_op_a | i_op_b;
            core_pkg::ALU_XOR:  result = i_op_a ^ i_op_b;
            core_pkg::ALU_SLL:  result = i_op_a << shamt;
            core_pkg::ALU_SRL:  result = i_op_a >> shamt;
            core_pkg::ALU_SRA:  result = core_pkg::data_t'($signed(i_op_a) >>> shamt);
            core_pkg::ALU_PASS: result = i_op_b;
            default:            result = sum;
        endcase
    end

    // register write commits at the next edge
    assign o_wr_en   = i_issue_valid;
    assign o_wr_addr = i_rd_addr;
    assign o_wr_data = result;

    always_ff @(posedge sck or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_valid <= 1'b0;
        end else begin
            o_wb_valid <= i_issue_valid;
        end
    end

    // report of the same write
    always_ff @(posedge sck) begin
        if (i_issue_valid) begin
            o_wb_addr <= i_rd_addr;
            o_wb_data <= result;
        end
    end

endmodule

`default_nettype wire

// ==== src/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder #(
    parameter int NUM_REGS = 32
) (
    input  wire                    sck,
    input  wire                    i_rst_n,
    input  wire                    i_cmd_valid,
    input  wire rv_isa_pkg::instr_t i_cmd,
    input  wire core_pkg::data_t   i_rs1_data,
    input  wire core_pkg::data_t   i_rs2_data,
    output core_pkg::reg_addr_t    o_rs1_addr,
    output core_pkg::reg_addr_t    o_rs2_addr,
    output core_pkg::reg_addr_t    o_rd_addr,
    output logic                   o_issue_valid,
    output logic                   o_illegal,
    output core_pkg::alu_op_e      o_alu_op,
    output core_pkg::data_t        o_op_a,
    output core_pkg::data_t        o_op_b
);

    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::funct3_t funct3;
    rv_isa_pkg::funct7_t funct7;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    core_pkg::reg_addr_t rd;
    core_pkg::data_t     imm_i;
    core_pkg::data_t     imm_u;
    core_pkg::data_t     op_b_nxt;
    core_pkg::alu_op_e   alu_op_nxt;
    logic                known;
    logic                use_rs1;
    logic                use_rs2;
    logic                bad_index;

    // field split
    assign opcode = i_cmd[6:0];
    assign rd     = i_cmd[11:7];
    assign funct3 = i_cmd[14:12];
    assign rs1    = i_cmd[19:15];
    assign rs2    = i_cmd[24:20];
    assign funct7 = i_cmd[31:25];

    assign imm_i = {{(core_pkg::XLEN - 12){i_cmd[31]}}, i_cmd[31:20]};
    assign imm_u = {i_cmd[31:12], 12'b0};

    // operand reads go straight to the register file
    assign o_rs1_addr = rs1;
    assign o_rs2_addr = rs2;

    always_comb begin
        known      = 1'b0;
        use_rs1    = 1'b0;
        use_rs2    = 1'b0;
        alu_op_nxt = core_pkg::ALU_ADD;
        op_b_nxt   = imm_i;
        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                op_b_nxt = i_rs2_data;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: begin
                        known = (funct7 == rv_isa_pkg::F7_BASE) ||
                                (funct7 == rv_isa_pkg::F7_ALT);
                        if (funct7 == rv_isa_pkg::F7_ALT) begin
                            alu_op_nxt = core_pkg::ALU_SUB;
                        end
                    end
                    rv_isa_pkg::F3_SR: begin
                        known = (funct7 == rv_isa_pkg::F7_BASE) ||
                                (funct7 == rv_isa_pkg::F7_ALT);
                        if (funct7 == rv_isa_pkg::F7_ALT) begin
                            alu_op_nxt = core_pkg::ALU_SRA;
                        end else begin
                            alu_op_nxt = core_pkg::ALU_SRL;
                        end
                    end
                    rv_isa_pkg::F3_SLL: begin
                        known      = (funct7 == rv_isa_pkg::F7_BASE);
                        alu_op_nxt = core_pkg::ALU_SLL;
                    end
                    rv_isa_pkg::F3_XOR: begin
                        known      = (funct7 == rv_isa_pkg::F7_BASE);
                        alu_op_nxt = core_pkg::ALU_XOR;
                    end
                    rv_isa_pkg::F3_OR: begin
                        known      = (funct7 == rv_isa_pkg::F7_BASE);
                        alu_op_nxt = core_pkg::ALU_OR;
                    end
                    rv_isa_pkg::F3_AND: begin
                        known      = (funct7 == rv_isa_pkg::F7_BASE);
                        alu_op_nxt = core_pkg::ALU_AND;
                    end
                    // slt and sltu are not supported
                    default: known = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                use_rs1 = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: known = 1'b1;
                    rv_isa_pkg::F3_SLL: begin
                        // shamt[5] set is illegal on rv32
                        known      = (funct7 == rv_isa_pkg::F7_BASE);
                        alu_op_nxt = core_pkg::ALU_SLL;
                    end
                    rv_isa_pkg::F3_SR: begin
                        known = (funct7 == rv_isa_pkg::F7_BASE) ||
                                (funct7 == rv_isa_pkg::F7_ALT);
                        if (funct7 == rv_isa_pkg::F7_ALT) begin
                            alu_op_nxt = core_pkg::ALU_SRA;
                        end else begin
                            alu_op_nxt = core_pkg::ALU_SRL;
                        end
                    end
                    rv_isa_pkg::F3_XOR: begin
                        known      = 1'b1;
                        alu_op_nxt = core_pkg::ALU_XOR;
                    end
                    rv_isa_pkg::F3_OR: begin
                        known      = 1'b1;
                        alu_op_nxt = core_pkg::ALU_OR;
                    end
                    rv_isa_pkg::F3_AND: begin
                        known      = 1'b1;
                        alu_op_nxt = core_pkg::ALU_AND;
                    end
                    default: known = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_LUI: begin
                known      = 1'b1;
                alu_op_nxt = core_pkg::ALU_PASS;
                op_b_nxt   = imm_u;
            end
            default: known = 1'b0;
        endcase
    end

    // indices beyond the implemented set, relevant for rv32e
    assign bad_index = (int'(rd) >= NUM_REGS) ||
                       (use_rs1 && (int'(rs1) >= NUM_REGS)) ||
                       (use_rs2 && (int'(rs2) >= NUM_REGS));

    always_ff @(posedge sck or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_issue_valid <= 1'b0;
            o_illegal     <= 1'b0;
        end else begin
            // writes to x0 are dropped here and never issued
            o_issue_valid <= i_cmd_valid && known && !bad_index && (rd != '0);
            o_illegal     <= i_cmd_valid && !(known && !bad_index);
        end
    end

    always_ff @(posedge sck) begin
        if (i_cmd_valid) begin
            o_alu_op  <= alu_op_nxt;
            o_op_a    <= i_rs1_data;
            o_op_b    <= op_b_nxt;
            o_rd_addr <= rd;
        end
    end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  wire                     sck,
    input  wire                     i_rst_n,
    input  wire core_pkg::reg_addr_t i_rs1_addr,
    input  wire core_pkg::reg_addr_t i_rs2_addr,
    input  wire core_pkg::reg_addr_t i_dbg_addr,
    input  wire core_pkg::reg_addr_t i_wr_addr,
    input  wire                     i_wr_en,
    input  wire core_pkg::data_t    i_wr_data,
    output core_pkg::data_t         o_rs1_data,
    output core_pkg::data_t         o_rs2_data,
    output core_pkg::data_t         o_dbg_data
);

    core_pkg::data_t regs [NUM_REGS];

    // unimplemented indices read as zero
    function automatic core_pkg::data_t stored(input core_pkg::reg_addr_t addr);
        core_pkg::data_t value;
        value = '0;
        if (int'(addr) < NUM_REGS) begin
            value = regs[addr];
        end
        return value;
    endfunction

    // x0 is cleared here and never written since the decoder drops those writes
    always_ff @(posedge sck or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (int'(i_wr_addr) < NUM_REGS)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // bypass the write that commits at the coming edge
    assign o_rs1_data = (i_wr_en && (i_wr_addr == i_rs1_addr)) ?
                        i_wr_data : stored(i_rs1_addr);
    assign o_rs2_data = (i_wr_en && (i_wr_addr == i_rs2_addr)) ?
                        i_wr_data : stored(i_rs2_addr);

    // debug view shows committed state only
    assign o_dbg_data = stored(i_dbg_addr);

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter int NUM_REGS = 32
) (
    input  wire                     sck,
    input  wire                     i_rst_n,
    input  wire                     i_cmd_valid,
    input  wire rv_isa_pkg::instr_t i_cmd,
    input  wire core_pkg::reg_addr_t i_dbg_addr,
    output core_pkg::data_t         o_dbg_data,
    output logic                    o_wb_valid,
    output core_pkg::reg_addr_t     o_wb_addr,
    output core_pkg::data_t         o_wb_data,
    output logic                    o_illegal
);

    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::reg_addr_t rd_addr;
    core_pkg::data_t     rs1_data;
    core_pkg::data_t     rs2_data;
    core_pkg::data_t     op_a;
    core_pkg::data_t     op_b;
    core_pkg::alu_op_e   alu_op;
    logic                issue_valid;
    logic                wr_en;
    core_pkg::reg_addr_t wr_addr;
    core_pkg::data_t     wr_data;

    // decode and operand fetch
    instr_decoder #(
        .NUM_REGS (NUM_REGS)
    ) u_decoder (
        .sck           (sck),
        .i_rst_n       (i_rst_n),
        .i_cmd_valid   (i_cmd_valid),
        .i_cmd         (i_cmd),
        .i_rs1_data    (rs1_data),
        .i_rs2_data    (rs2_data),
        .o_rs1_addr    (rs1_addr),
        .o_rs2_addr    (rs2_addr),
        .o_rd_addr     (rd_addr),
        .o_issue_valid (issue_valid),
        .o_illegal     (o_illegal),
        .o_alu_op      (alu_op),
        .o_op_a        (op_a),
        .o_op_b        (op_b)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_regs (
        .sck        (sck),
        .i_rst_n    (i_rst_n),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_dbg_addr (i_dbg_addr),
        .i_wr_addr  (wr_addr),
        .i_wr_en    (wr_en),
        .i_wr_data  (wr_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .o_dbg_data (o_dbg_data)
    );

    // alu and write-back
    exec_unit u_exec (
        .sck           (sck),
        .i_rst_n       (i_rst_n),
        .i_issue_valid (issue_valid),
        .i_alu_op      (alu_op),
        .i_op_a        (op_a),
        .i_op_b        (op_b),
        .i_rd_addr     (rd_addr),
        .o_wr_en       (wr_en),
        .o_wr_addr     (wr_addr),
        .o_wr_data     (wr_data),
        .o_wb_valid    (o_wb_valid),
        .o_wb_addr     (o_wb_addr),
        .o_wb_data     (o_wb_data)
    );

endmodule

`default_nettype wire

// ==== src/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // one raw instruction word
    typedef logic [31:0] instr_t;

    // instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // major opcodes of the supported groups
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // funct3 codes shared by register and immediate forms
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SR      = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // funct7 values, alt selects sub and sra
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire
